// ==== logic/hold_timer.sv ====
`timescale 1ns/1ps

module hold_timer #(
	parameter int HOLD_TICKS = piano_pkg::HOLD_TICK_CYCLES
) (
	input  logic CLOCK_50,
	input  logic rst_n,
	output logic tick
);
	import piano_pkg::*;

	logic [HOLD_CNT_W-1:0] count;

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			count <= HOLD_CNT_W'(HOLD_TICKS - 1);
		end else if (count == '0) begin
			count <= HOLD_CNT_W'(HOLD_TICKS - 1); // Reload on wrap
		end else begin
			count <= count - 1'b1;
		end
	end

	// One cycle per period, last cycle of the count
	assign tick = (count == '0);

endmodule

// ==== logic/key_decoder.sv ====
`timescale 1ns/1ps

module key_decoder (
	input  piano_pkg::scancode_t                held_code,
	output piano_pkg::piano_key_t               key,
	output logic [piano_pkg::HALF_PERIOD_W-1:0] half_period,
	output logic                                note_on
);
	import piano_pkg::*;

	always_comb begin
		case (held_code)
			SC_TAB:       key = KEY_W0;
			SC_Q:         key = KEY_W1;
			SC_W:         key = KEY_W2;
			SC_E:         key = KEY_W3;
			SC_R:         key = KEY_W4;
			SC_T:         key = KEY_W5;
			SC_Y:         key = KEY_W6;
			SC_U:         key = KEY_W7;
			SC_I:         key = KEY_W8;
			SC_O:         key = KEY_W9;
			SC_P:         key = KEY_W10;
			SC_LBRACKET:  key = KEY_W11;
			SC_RBRACKET:  key = KEY_W12;
			SC_BACKSLASH: key = KEY_W13;
			SC_1:         key = KEY_B0;
			SC_2:         key = KEY_B1;
			SC_4:         key = KEY_B2;
			SC_5:         key = KEY_B3;
			SC_6:         key = KEY_B4;
			SC_8:         key = KEY_B5;
			SC_9:         key = KEY_B6;
			SC_MINUS:     key = KEY_B7;
			SC_EQUALS:    key = KEY_B8;
			SC_BACKSPACE: key = KEY_B9;
			default:      key = KEY_NONE; // Cleared or unmapped code
		endcase
	end

	// Table order follows the key enum
	always_comb begin
		half_period = '0;
		if (key != KEY_NONE)
			half_period = TONE_HALF_PERIOD[key];
	end

	assign note_on = (key != KEY_NONE);

endmodule

// ==== logic/keyboard_renderer.sv ====
`timescale 1ns/1ps

module keyboard_renderer (
	input  logic                          CLOCK_50,
	input  logic                          rst_n,
	input  logic [piano_pkg::PIX_X_W-1:0] x,
	input  logic [piano_pkg::PIX_Y_W-1:0] y,
	input  piano_pkg::piano_key_t         key,
	output logic [piano_pkg::PIX_X_W-1:0] pixel_x,
	output logic [piano_pkg::PIX_Y_W-1:0] pixel_y,
	output piano_pkg::colour_t            pixel_colour
);
	import piano_pkg::*;

	logic       in_black_band;
	logic       in_white_band;
	logic       in_keys_x;
	logic       white_hit;
	logic       black_hit;
	logic [3:0] white_idx;
	logic [3:0] black_idx;
	piano_key_t white_key;
	piano_key_t black_key;
	colour_t    colour_next;

	assign in_black_band = (y >= TOP_ROW) && (y <= BLACK_BAND_END);
	assign in_white_band = (y >= WHITE_BAND_TOP) && (y < KEY_LINE_ROW);
	assign in_keys_x     = (x > LEFT_EDGE) && (x <= RIGHT_EDGE);

	// White key spans, gaps between them are the separator columns
	always_comb begin
		white_hit = 1'b0;
		white_idx = '0;
		for (int i = 0; i < NUM_WHITE_KEYS; i++) begin
			if ((x >= LEFT_EDGE + 1 + i * WHITE_KEY_PITCH) &&
				(x < LEFT_EDGE + 1 + i * WHITE_KEY_PITCH + WHITE_KEY_W)) begin
				white_hit = 1'b1;
				white_idx = 4'(i);
			end
		end
	end

	always_comb begin
		black_hit = 1'b0;
		black_idx = '0;
		for (int j = 0; j < NUM_BLACK_KEYS; j++) begin
			if ((x >= BLACK_KEY_X0[j]) && (x < BLACK_KEY_X0[j] + BLACK_KEY_W)) begin
				black_hit = 1'b1;
				black_idx = 4'(j);
			end
		end
	end

	assign white_key = piano_key_t'(white_idx);
	assign black_key = piano_key_t'(NUM_WHITE_KEYS + int'(black_idx));

	always_comb begin
		if (y > KEY_LINE_ROW)
			colour_next = CLR_WHITE; // Bottom area
		else if (!in_keys_x || !(in_black_band || in_white_band))
			colour_next = CLR_BLACK; // Frame, top area and key line
		else if (in_black_band && black_hit)
			colour_next = (black_key == key) ? CLR_RED : CLR_BLACK;
		else if (white_hit)
			colour_next = (white_key == key) ? CLR_RED : CLR_WHITE;
		else
			colour_next = CLR_BLACK; // Separator
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			// Last pixel of the frame, so the stream wraps into (0,0)
			pixel_x      <= PIX_X_W'(SCREEN_W - 1);
			pixel_y      <= PIX_Y_W'(SCREEN_H - 1);
			pixel_colour <= CLR_WHITE;
		end else begin
			pixel_x      <= x;
			pixel_y      <= y;
			pixel_colour <= colour_next;
		end
	end

endmodule

// ==== logic/note_hold_fsm.sv ====
`timescale 1ns/1ps

module note_hold_fsm (
	input  logic                 CLOCK_50,
	input  logic                 rst_n,
	input  piano_pkg::scancode_t scancode,
	input  logic                 scancode_valid,
	input  logic                 tick,
	output piano_pkg::scancode_t held_code
);
	import piano_pkg::*;

	hold_state_t state;
	hold_state_t state_next;

	always_comb begin
		state_next = state;
		case (state)
			HOLD_EMPTY: begin
				if (scancode_valid)
					state_next = HOLD_FIRST;
			end
			HOLD_FIRST: begin
				if (tick)
					state_next = HOLD_SECOND;
			end
			HOLD_SECOND: begin
				if (tick)
					state_next = scancode_valid ? HOLD_FIRST : HOLD_EMPTY;
			end
			default: state_next = HOLD_EMPTY;
		endcase
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			state     <= HOLD_EMPTY;
			held_code <= '0;
		end else begin
			state <= state_next;
			if (scancode_valid)
				held_code <= scancode; // New key beats the clear
			else if (tick && state == HOLD_SECOND)
				held_code <= '0;
		end
	end

endmodule

// ==== logic/piano_pkg.sv ====
package piano_pkg;

	typedef logic [7:0] scancode_t;

	// PS/2 make codes, white keys left to right
	localparam scancode_t SC_TAB       = 8'h0D;
	localparam scancode_t SC_Q         = 8'h15;
	localparam scancode_t SC_W         = 8'h1D;
	localparam scancode_t SC_E         = 8'h24;
	localparam scancode_t SC_R         = 8'h2D;
	localparam scancode_t SC_T         = 8'h2C;
	localparam scancode_t SC_Y         = 8'h35;
	localparam scancode_t SC_U         = 8'h3C;
	localparam scancode_t SC_I         = 8'h43;
	localparam scancode_t SC_O         = 8'h44;
	localparam scancode_t SC_P         = 8'h4D;
	localparam scancode_t SC_LBRACKET  = 8'h54;
	localparam scancode_t SC_RBRACKET  = 8'h5B;
	localparam scancode_t SC_BACKSLASH = 8'h5D;
	// Black keys left to right
	localparam scancode_t SC_1         = 8'h16;
	localparam scancode_t SC_2         = 8'h1E;
	localparam scancode_t SC_4         = 8'h25;
	localparam scancode_t SC_5         = 8'h2E;
	localparam scancode_t SC_6         = 8'h36;
	localparam scancode_t SC_8         = 8'h3E;
	localparam scancode_t SC_9         = 8'h46;
	localparam scancode_t SC_MINUS     = 8'h4E;
	localparam scancode_t SC_EQUALS    = 8'h55;
	localparam scancode_t SC_BACKSPACE = 8'h66;

	typedef enum logic [4:0] {
		KEY_W0, KEY_W1, KEY_W2, KEY_W3, KEY_W4, KEY_W5, KEY_W6,
		KEY_W7, KEY_W8, KEY_W9, KEY_W10, KEY_W11, KEY_W12, KEY_W13,
		KEY_B0, KEY_B1, KEY_B2, KEY_B3, KEY_B4,
		KEY_B5, KEY_B6, KEY_B7, KEY_B8, KEY_B9,
		KEY_NONE
	} piano_key_t;

	localparam int NUM_WHITE_KEYS = 14;
	localparam int NUM_BLACK_KEYS = 10;
	localparam int NUM_KEYS       = 24;

	typedef logic [2:0] colour_t;

	localparam colour_t CLR_RED   = 3'b100;
	localparam colour_t CLR_WHITE = 3'b111;
	localparam colour_t CLR_BLACK = 3'b000;

	localparam int SCREEN_W = 160;
	localparam int SCREEN_H = 120;
	localparam int PIX_X_W  = 8;
	localparam int PIX_Y_W  = 7;

	localparam int TOP_ROW         = 34;
	localparam int BLACK_BAND_END  = 68;
	localparam int WHITE_BAND_TOP  = 69;
	localparam int KEY_LINE_ROW    = 83;
	localparam int LEFT_EDGE       = 3;
	localparam int RIGHT_EDGE      = 156;
	localparam int WHITE_KEY_PITCH = 11;
	localparam int WHITE_KEY_W     = 10;
	localparam int BLACK_KEY_W     = 7;
	localparam int BLACK_KEY_X0 [NUM_BLACK_KEYS] = '{11, 22, 44, 55, 66, 88, 99, 121, 132, 143};

	localparam int HALF_PERIOD_W = 19;
	// 25e6 / f, C3 to B4 whites then C#3 to A#4 blacks
	localparam logic [HALF_PERIOD_W-1:0] TONE_HALF_PERIOD [NUM_KEYS] = '{
		19'd191112, 19'd170262, 19'd151686, 19'd143172, 19'd127552, 19'd113636, 19'd101238,
		19'd95556, 19'd85131, 19'd75843, 19'd71586, 19'd63776, 19'd56818, 19'd50619,
		19'd180386, 19'd160706, 19'd135137, 19'd120393, 19'd107258,
		19'd90193, 19'd80353, 19'd67568, 19'd60196, 19'd53629
	};

	localparam int SAMPLE_W = 32;
	localparam logic signed [SAMPLE_W-1:0] TONE_AMPLITUDE = 32'sd10_000_000;

	localparam int HOLD_TICK_CYCLES = 25_000_000;
	localparam int HOLD_CNT_W       = 25;

	typedef enum logic [1:0] {
		HOLD_EMPTY,
		HOLD_FIRST,
		HOLD_SECOND
	} hold_state_t;

endpackage

// ==== logic/piano_top.sv ====
`timescale 1ns/1ps

module piano_top #(
	parameter int HOLD_TICKS = piano_pkg::HOLD_TICK_CYCLES
) (
	input  logic                                  CLOCK_50,
	input  logic                                  rst_n,
	input  piano_pkg::scancode_t                  scancode,
	input  logic                                  scancode_valid,
	output logic [piano_pkg::PIX_X_W-1:0]         pixel_x,
	output logic [piano_pkg::PIX_Y_W-1:0]         pixel_y,
	output piano_pkg::colour_t                    pixel_colour,
	output piano_pkg::piano_key_t                 active_key,
	output logic                                  note_on,
	output logic signed [piano_pkg::SAMPLE_W-1:0] sample
);
	import piano_pkg::*;

	logic                     tick;
	scancode_t                held_code;
	logic [HALF_PERIOD_W-1:0] half_period;
	logic [PIX_X_W-1:0]       x;
	logic [PIX_Y_W-1:0]       y;

	hold_timer #(.HOLD_TICKS(HOLD_TICKS)) i_hold_timer (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.tick     (tick)
	);

	note_hold_fsm i_note_hold_fsm (
		.CLOCK_50       (CLOCK_50),
		.rst_n          (rst_n),
		.scancode       (scancode),
		.scancode_valid (scancode_valid),
		.tick           (tick),
		.held_code      (held_code)
	);

	key_decoder i_key_decoder (
		.held_code   (held_code),
		.key         (active_key),
		.half_period (half_period),
		.note_on     (note_on)
	);

	tone_generator i_tone_generator (
		.CLOCK_50    (CLOCK_50),
		.rst_n       (rst_n),
		.half_period (half_period),
		.note_on     (note_on),
		.sample      (sample)
	);

	pixel_scanner i_pixel_scanner (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.x        (x),
		.y        (y)
	);

	keyboard_renderer i_keyboard_renderer (
		.CLOCK_50     (CLOCK_50),
		.rst_n        (rst_n),
		.x            (x),
		.y            (y),
		.key          (active_key), // Registered with the pixel, so one cycle late
		.pixel_x      (pixel_x),
		.pixel_y      (pixel_y),
		.pixel_colour (pixel_colour)
	);

endmodule

// ==== logic/pixel_scanner.sv ====
`timescale 1ns/1ps

module pixel_scanner (
	input  logic                          CLOCK_50,
	input  logic                          rst_n,
	output logic [piano_pkg::PIX_X_W-1:0] x,
	output logic [piano_pkg::PIX_Y_W-1:0] y
);
	import piano_pkg::*;

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			x <= '0;
			y <= '0;
		end else if (x == PIX_X_W'(SCREEN_W - 1)) begin
			x <= '0; // End of line
			if (y == PIX_Y_W'(SCREEN_H - 1))
				y <= '0;
			else
				y <= y + 1'b1;
		end else begin
			x <= x + 1'b1;
		end
	end

endmodule

// ==== logic/tone_generator.sv ====
`timescale 1ns/1ps

module tone_generator (
	input  logic                                 CLOCK_50,
	input  logic                                 rst_n,
	input  logic [piano_pkg::HALF_PERIOD_W-1:0]  half_period,
	input  logic                                 note_on,
	output logic signed [piano_pkg::SAMPLE_W-1:0] sample
);
	import piano_pkg::*;

	logic [HALF_PERIOD_W-1:0] count;
	logic                     phase;

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
			phase <= 1'b0;
		end else if (!note_on) begin
			count <= '0; // Start each note on a fresh half-cycle
		end else if (count >= half_period) begin
			count <= '0; // Also catches a shorter period after a key change
			phase <= ~phase;
		end else begin
			count <= count + 1'b1;
		end
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n)
			sample <= '0;
		else if (!note_on)
			sample <= '0;
		else if (phase)
			sample <= TONE_AMPLITUDE;
		else
			sample <= -TONE_AMPLITUDE;
	end

endmodule

// ==== test/piano_model.svh ====
`ifndef PIANO_MODEL_SVH
`define PIANO_MODEL_SVH

// Mapped scancodes, white keys then black keys
function automatic logic [7:0] mapped_code(input int idx);
	logic [7:0] codes [24];
	codes = '{8'h0D, 8'h15, 8'h1D, 8'h24, 8'h2D, 8'h2C, 8'h35, 8'h3C, 8'h43, 8'h44,
		8'h4D, 8'h54, 8'h5B, 8'h5D, 8'h16, 8'h1E, 8'h25, 8'h2E, 8'h36, 8'h3E,
		8'h46, 8'h4E, 8'h55, 8'h66};
	return codes[idx];
endfunction

function automatic piano_key_t decode_key(input logic [7:0] code);
	for (int i = 0; i < 24; i++) begin
		if (mapped_code(i) == code)
			return piano_key_t'(i); // Key order matches the code order
	end
	return KEY_NONE;
endfunction

// Equal temperament, C3 upwards
function automatic int note_half_period(input piano_key_t key);
	int  midi [24];
	real freq;
	midi = '{48, 50, 52, 53, 55, 57, 59, 60, 62, 64, 65, 67, 69, 71,
		49, 51, 54, 56, 58, 61, 63, 66, 68, 70};
	if (key == KEY_NONE)
		return 0;
	freq = 440.0 * (2.0 ** ((midi[int'(key)] - 69) / 12.0));
	return $rtoi(25000000.0 / freq); // Truncated
endfunction

function automatic logic [2:0] colour_at(input int x, input int y, input piano_key_t key);
	int x0 [10];
	int idx;
	x0 = '{11, 22, 44, 55, 66, 88, 99, 121, 132, 143};
	if (y > 83)
		return 3'b111;
	if (y < 34 || y == 83 || x < 4 || x > 156)
		return 3'b000;
	if (y <= 68) begin
		for (int j = 0; j < 10; j++) begin
			if (x >= x0[j] && x < x0[j] + 7)
				return (int'(key) == 14 + j) ? 3'b100 : 3'b000;
		end
	end
	idx = (x - 4) / 11;
	if ((x - 4) % 11 == 10)
		return 3'b000; // Separator column
	return (int'(key) == idx) ? 3'b100 : 3'b111;
endfunction

`endif

// ==== test/tb_piano.sv ====
`timescale 1ns/1ps

module tb_piano;
	import piano_pkg::*;

	`include "piano_model.svh"

	localparam int HOLD = 64;

	logic              CLOCK_50;
	logic              rst_n;
	logic [7:0]        scancode;
	logic              scancode_valid;
	logic [7:0]        pixel_x;
	logic [6:0]        pixel_y;
	logic [2:0]        pixel_colour;
	piano_key_t        active_key;
	logic              note_on;
	logic signed [31:0] sample;

	int          errors = 0;
	int          checks = 0;
	int          tone_intervals = 0;
	int          cycle = 0;
	int          last_change = 0;
	bit          have_change = 0;
	bit          checks_on = 0;
	logic [31:0] lfsr = 32'h992e_e87d;
	// Hold model, timer count, ticks left and code
	int          tcnt_m = HOLD - 1;
	int          ticks_left_m = 0;
	logic [7:0]  held_m = '0;
	int          prev_px;
	int          prev_py;
	int          exp_x;
	int          exp_y;
	piano_key_t  prev_key;
	logic        prev_note;
	logic signed [31:0] prev_sample;
	logic [31:0] magnitude;

	piano_top #(.HOLD_TICKS(HOLD)) i_piano_top (
		.CLOCK_50       (CLOCK_50),
		.rst_n          (rst_n),
		.scancode       (scancode),
		.scancode_valid (scancode_valid),
		.pixel_x        (pixel_x),
		.pixel_y        (pixel_y),
		.pixel_colour   (pixel_colour),
		.active_key     (active_key),
		.note_on        (note_on),
		.sample         (sample)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #4 CLOCK_50 = ~CLOCK_50;
	end

	function automatic int unsigned random_bits(input int n);
		int unsigned r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			r    = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s got %h expected %h at cycle %0d", name, got, exp, cycle);
		end
	endtask

	always @(posedge CLOCK_50) begin
		checks_on <= rst_n;
		if (rst_n) begin
			if (tcnt_m == 0 && ticks_left_m == 1) begin
				held_m       <= scancode_valid ? scancode : 8'h00; // Second tick clears
				ticks_left_m <= scancode_valid ? 2 : 0;
			end else begin
				if (scancode_valid)
					held_m <= scancode;
				if (scancode_valid && ticks_left_m == 0)
					ticks_left_m <= 2; // Hold starts from empty
				else if (tcnt_m == 0 && ticks_left_m == 2)
					ticks_left_m <= 1;
			end
			if (tcnt_m == 0)
				tcnt_m <= HOLD - 1;
			else
				tcnt_m <= tcnt_m - 1;
		end
	end

	always @(negedge CLOCK_50) begin
		if (!checks_on) begin
			prev_px     = 159; // Stream wraps into (0,0)
			prev_py     = 119;
			prev_key    = KEY_NONE;
			prev_note   = 1'b0;
			prev_sample = '0;
			have_change = 0;
		end else begin
			cycle++;
			exp_x = (prev_px == 159) ? 0 : prev_px + 1;
			exp_y = (prev_px != 159) ? prev_py : ((prev_py == 119) ? 0 : prev_py + 1);
			check_value("pixel_x", pixel_x, exp_x);
			check_value("pixel_y", pixel_y, exp_y);
			check_value("pixel_colour", pixel_colour, colour_at(pixel_x, pixel_y, prev_key));
			check_value("active_key", active_key, decode_key(held_m));
			check_value("note_on", note_on, decode_key(held_m) != KEY_NONE);
			magnitude = (sample < 0) ? -sample : sample;
			check_value("sample", magnitude, prev_note ? 32'd10_000_000 : 32'd0);
			if (!note_on || active_key != prev_key)
				have_change = 0; // Interval spans a key change
			if (sample != 0 && prev_sample != 0 && (sample < 0) != (prev_sample < 0)) begin
				if (have_change) begin
					check_value("sample_interval", cycle - last_change,
						note_half_period(active_key) + 1);
					tone_intervals++;
				end
				last_change = cycle;
				have_change = 1;
			end
			prev_px     = pixel_x;
			prev_py     = pixel_y;
			prev_key    = active_key;
			prev_note   = note_on;
			prev_sample = sample;
		end
	end

	task automatic drive_strobe(input logic [7:0] code);
		scancode       = code;
		scancode_valid = 1'b1;
		@(negedge CLOCK_50);
		scancode_valid = 1'b0;
	endtask

	task automatic wait_note_off();
		int n;
		n = 0;
		while (note_on && n < 140) begin
			@(negedge CLOCK_50);
			n++;
		end
		if (note_on) begin
			errors++;
			$display("Timeout: note_on still high 140 cycles after the last strobe");
		end
	endtask

	// Re-strobe on every tick so the note never drops
	task automatic hold_tone(input int idx);
		logic [7:0] code;
		int         target;
		int         limit;
		int         n;
		code   = mapped_code(idx);
		target = tone_intervals + 2;
		limit  = 4 * (note_half_period(decode_key(code)) + 1) + 200;
		n      = 0;
		scancode = code;
		while (tone_intervals < target && n < limit) begin
			scancode_valid = (n == 0) || (tcnt_m == 0);
			@(negedge CLOCK_50);
			n++;
		end
		scancode_valid = 1'b0;
		if (tone_intervals < target) begin
			errors++;
			$display("Timeout: no steady sign changes on sample for key index %0d", idx);
		end
		wait_note_off();
	endtask

	initial begin
		int unsigned gap;
		rst_n          = 1'b0;
		scancode       = '0;
		scancode_valid = 1'b0;
		repeat (16) @(negedge CLOCK_50);
		rst_n = 1'b1;
		repeat (3) @(negedge CLOCK_50);
		for (int k = 0; k < 80; k++) begin
			if (random_bits(3) == 0)
				drive_strobe(random_bits(8)); // Mostly unmapped
			else
				drive_strobe(mapped_code(random_bits(5) % 24));
			if (random_bits(1))
				wait_note_off();
			else begin
				gap = random_bits(7);
				repeat (gap) @(negedge CLOCK_50);
			end
		end
		hold_tone(random_bits(5) % 24);
		hold_tone(random_bits(5) % 24);
		repeat (19200) @(negedge CLOCK_50); // One full frame with no key
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+test
logic/piano_pkg.sv
logic/hold_timer.sv
logic/note_hold_fsm.sv
logic/key_decoder.sv
logic/tone_generator.sv
logic/pixel_scanner.sv
logic/keyboard_renderer.sv
logic/piano_top.sv
test/tb_piano.sv
